// File: rtl/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// datapath and instruction widths
`define XLEN 32
`define INSTR_W 32
`define REG_ADDR_W 5
`define SHAMT_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// major opcodes of the supported subset
`define OPC_OP 7'b0110011
`define OPC_OPIMM 7'b0010011
`define OPC_LUI 7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111

// funct3 values for ALU and branch forms
`define F3_ADD 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SR 3'b101
`define F3_OR 3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001

// funct7 values where alt selects sub and sra
`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000

`endif

// File: rtl/pipePkg.sv
package pipePkg;

    // ALU functions
    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr = 4'd3,
        AluXor = 4'd4,
        AluSll = 4'd5,
        AluSrl = 4'd6,
        AluSra = 4'd7,
        AluSlt = 4'd8,
        AluSltu = 4'd9,
        // result is operand B, for LUI and the JAL link value
        AluPassB = 4'd10
    } AluOp;

    // control transfer kind, resolved in execute
    typedef enum logic [1:0] {
        BrNone = 2'd0,
        BrEq = 2'd1,
        BrNe = 2'd2,
        BrJump = 2'd3
    } BranchKind;

endpackage

// File: rtl/fetchStage.sv
`include "pipe_consts.svh"

module fetchStage (
    input logic clk,
    input logic rst,
    input logic en,
    input logic redirect,
    input logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] instrAddr,
    input logic [`INSTR_W-1:0] instrData,
    output logic fetchValid,
    output logic [`XLEN-1:0] fetchPc,
    output logic [`INSTR_W-1:0] fetchInstr
);

    logic [`XLEN-1:0] pc;

    assign instrAddr = pc;

    // sequential fetch unless execute resolves a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (en) begin
            if (redirect)
                pc <= redirectPc;
            else
                pc <= pc + `XLEN'd4;
        end
    end

    // word fetched on the wrong path is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchValid <= 1'b0;
        end else if (en) begin
            fetchValid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            fetchPc <= pc;
            fetchInstr <= instrData;
        end
    end

endmodule

// File: rtl/regFile.sv
`include "pipe_consts.svh"

module regFile (
    input logic clk,
    input logic [`REG_ADDR_W-1:0] rs1Addr,
    input logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data,
    input logic wrEn,
    input logic [`REG_ADDR_W-1:0] wrAddr,
    input logic [`XLEN-1:0] wrData
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    // x0 is hardwired and a same-cycle write is passed through
    function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            readReg = '0;
        else if (wrEn && wrAddr == addr)
            readReg = wrData;
        else
            readReg = regs[addr];
    endfunction

    always_comb begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != '0)
            regs[wrAddr] <= wrData;
    end

endmodule

// File: rtl/decodeStage.sv
`include "pipe_consts.svh"

module decodeStage (
    input logic clk,
    input logic rst,
    input logic en,
    input logic redirect,
    input logic fetchValid,
    input logic [`XLEN-1:0] fetchPc,
    input logic [`INSTR_W-1:0] fetchInstr,
    input logic retValid,
    input logic [`REG_ADDR_W-1:0] retRd,
    input logic [`XLEN-1:0] retData,
    input logic retWrites,
    output logic decValid,
    output logic [`XLEN-1:0] decPc,
    output pipePkg::AluOp decAluOp,
    output pipePkg::BranchKind decBranchKind,
    output logic [`REG_ADDR_W-1:0] decRd,
    output logic [`REG_ADDR_W-1:0] decRs1,
    output logic [`REG_ADDR_W-1:0] decRs2,
    output logic [`XLEN-1:0] decOpA,
    output logic [`XLEN-1:0] decOpB,
    output logic [`XLEN-1:0] decImm,
    output logic decWrites
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [`REG_ADDR_W-1:0] rdField;
    logic [`REG_ADDR_W-1:0] rs1Field;
    logic [`REG_ADDR_W-1:0] rs2Field;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immJ;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic opLegal;
    logic opImmLegal;
    pipePkg::AluOp aluOp;
    pipePkg::BranchKind branchKind;
    logic writes;
    logic useRs1;
    logic useRs2;
    logic bIsImm;
    logic [`XLEN-1:0] imm;

    assign opcode = fetchInstr[6:0];
    assign rdField = fetchInstr[11:7];
    assign funct3 = fetchInstr[14:12];
    assign rs1Field = fetchInstr[19:15];
    assign rs2Field = fetchInstr[24:20];
    assign funct7 = fetchInstr[31:25];

    assign immI = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
    assign immU = {fetchInstr[31:12], 12'b0};
    assign immB = {{19{fetchInstr[31]}}, fetchInstr[31], fetchInstr[7],
                   fetchInstr[30:25], fetchInstr[11:8], 1'b0};
    assign immJ = {{11{fetchInstr[31]}}, fetchInstr[31], fetchInstr[19:12],
                   fetchInstr[20], fetchInstr[30:21], 1'b0};

    // funct7 alt is only defined for sub and sra
    assign opLegal = (funct7 == `F7_BASE) ||
                     (funct7 == `F7_ALT && (funct3 == `F3_ADD || funct3 == `F3_SR));
    assign opImmLegal = (funct3 == `F3_SLL) ? (funct7 == `F7_BASE) :
                        (funct3 == `F3_SR) ? (funct7 == `F7_BASE || funct7 == `F7_ALT) :
                        1'b1;

    function automatic pipePkg::AluOp aluFromFunct(input logic [2:0] f3, input logic alt,
                                                   input logic isReg);
        case (f3)
            `F3_ADD: aluFromFunct = (isReg && alt) ? pipePkg::AluSub : pipePkg::AluAdd;
            `F3_SLL: aluFromFunct = pipePkg::AluSll;
            `F3_SLT: aluFromFunct = pipePkg::AluSlt;
            `F3_SLTU: aluFromFunct = pipePkg::AluSltu;
            `F3_XOR: aluFromFunct = pipePkg::AluXor;
            `F3_SR: aluFromFunct = alt ? pipePkg::AluSra : pipePkg::AluSrl;
            `F3_OR: aluFromFunct = pipePkg::AluOr;
            default: aluFromFunct = pipePkg::AluAnd;
        endcase
    endfunction

    // unknown encodings fall through as no-write, no-branch
    always_comb begin
        aluOp = pipePkg::AluAdd;
        branchKind = pipePkg::BrNone;
        writes = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        bIsImm = 1'b0;
        imm = immI;
        case (opcode)
            `OPC_OP: begin
                writes = opLegal;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                aluOp = aluFromFunct(funct3, fetchInstr[30], 1'b1);
            end
            `OPC_OPIMM: begin
                writes = opImmLegal;
                useRs1 = 1'b1;
                bIsImm = 1'b1;
                aluOp = aluFromFunct(funct3, fetchInstr[30], 1'b0);
            end
            `OPC_LUI: begin
                writes = 1'b1;
                bIsImm = 1'b1;
                imm = immU;
                aluOp = pipePkg::AluPassB;
            end
            `OPC_BRANCH: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                imm = immB;
                if (funct3 == `F3_BEQ)
                    branchKind = pipePkg::BrEq;
                else if (funct3 == `F3_BNE)
                    branchKind = pipePkg::BrNe;
            end
            `OPC_JAL: begin
                writes = 1'b1;
                imm = immJ;
                branchKind = pipePkg::BrJump;
                aluOp = pipePkg::AluPassB;
            end
            default: begin
            end
        endcase
    end

    regFile rf (
        .clk(clk),
        .rs1Addr(rs1Field),
        .rs2Addr(rs2Field),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .wrEn(retValid && retWrites && retRd != '0),
        .wrAddr(retRd),
        .wrData(retData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (en) begin
            decValid <= fetchValid && !redirect;
        end
    end

    // unused sources become x0 so execute never forwards into them
    always_ff @(posedge clk) begin
        if (en) begin
            decPc <= fetchPc;
            decAluOp <= aluOp;
            decBranchKind <= branchKind;
            decRd <= writes ? rdField : '0;
            decRs1 <= useRs1 ? rs1Field : '0;
            decRs2 <= useRs2 ? rs2Field : '0;
            decOpA <= rs1Data;
            decOpB <= bIsImm ? imm : rs2Data;
            decImm <= imm;
            decWrites <= writes;
        end
    end

endmodule

// File: rtl/executeStage.sv
`include "pipe_consts.svh"

module executeStage (
    input logic clk,
    input logic rst,
    input logic en,
    input logic decValid,
    input logic [`XLEN-1:0] decPc,
    input pipePkg::AluOp decAluOp,
    input pipePkg::BranchKind decBranchKind,
    input logic [`REG_ADDR_W-1:0] decRd,
    input logic [`REG_ADDR_W-1:0] decRs1,
    input logic [`REG_ADDR_W-1:0] decRs2,
    input logic [`XLEN-1:0] decOpA,
    input logic [`XLEN-1:0] decOpB,
    input logic [`XLEN-1:0] decImm,
    input logic decWrites,
    output logic redirect,
    output logic [`XLEN-1:0] redirectPc,
    output logic retValid,
    output logic [`XLEN-1:0] retPc,
    output logic [`REG_ADDR_W-1:0] retRd,
    output logic [`XLEN-1:0] retData,
    output logic retWrites
);

    logic retValidQ;
    logic fwdOk;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluB;
    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0] aluOut;
    logic taken;

    // retire stays hidden while the pipeline is held
    assign retValid = retValidQ && en;

    // distance 1 comes from here, distance 2 from the regfile bypass
    assign fwdOk = retValid && retWrites && retRd != '0;
    assign opA = (fwdOk && decRs1 == retRd) ? retData : decOpA;
    assign opB = (fwdOk && decRs2 == retRd) ? retData : decOpB;

    // JAL writes the link address through pass-B
    assign aluB = (decBranchKind == pipePkg::BrJump) ? decPc + `XLEN'd4 : opB;
    assign shamt = aluB[`SHAMT_W-1:0];

    always_comb begin
        case (decAluOp)
            pipePkg::AluAdd: aluOut = opA + aluB;
            pipePkg::AluSub: aluOut = opA - aluB;
            pipePkg::AluAnd: aluOut = opA & aluB;
            pipePkg::AluOr: aluOut = opA | aluB;
            pipePkg::AluXor: aluOut = opA ^ aluB;
            pipePkg::AluSll: aluOut = opA << shamt;
            pipePkg::AluSrl: aluOut = opA >> shamt;
            pipePkg::AluSra: aluOut = $signed(opA) >>> shamt;
            pipePkg::AluSlt: aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            pipePkg::AluSltu: aluOut = {{(`XLEN-1){1'b0}}, opA < aluB};
            default: aluOut = aluB;
        endcase
    end

    always_comb begin
        case (decBranchKind)
            pipePkg::BrEq: taken = (opA == opB);
            pipePkg::BrNe: taken = (opA != opB);
            pipePkg::BrJump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // flushes fetch and decode at the next edge
    assign redirect = en && decValid && taken;
    assign redirectPc = decPc + decImm;

    always_ff @(posedge clk) begin
        if (rst) begin
            retValidQ <= 1'b0;
        end else if (en) begin
            retValidQ <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            retPc <= decPc;
            retRd <= decRd;
            retData <= aluOut;
            retWrites <= decWrites;
        end
    end

endmodule

// File: rtl/miniCore.sv
`include "pipe_consts.svh"

module miniCore (
    input logic clk,
    input logic rst,
    input logic en,
    output logic [`XLEN-1:0] instrAddr,
    input logic [`INSTR_W-1:0] instrData,
    output logic retValid,
    output logic [`XLEN-1:0] retPc,
    output logic [`REG_ADDR_W-1:0] retRd,
    output logic [`XLEN-1:0] retData,
    output logic retWrites
);

    logic redirect;
    logic [`XLEN-1:0] redirectPc;

    logic fetchValid;
    logic [`XLEN-1:0] fetchPc;
    logic [`INSTR_W-1:0] fetchInstr;

    logic decValid;
    logic [`XLEN-1:0] decPc;
    pipePkg::AluOp decAluOp;
    pipePkg::BranchKind decBranchKind;
    logic [`REG_ADDR_W-1:0] decRd;
    logic [`REG_ADDR_W-1:0] decRs1;
    logic [`REG_ADDR_W-1:0] decRs2;
    logic [`XLEN-1:0] decOpA;
    logic [`XLEN-1:0] decOpB;
    logic [`XLEN-1:0] decImm;
    logic decWrites;

    fetchStage fetch (
        .clk(clk),
        .rst(rst),
        .en(en),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr)
    );

    // retire group feeds back as the regfile write port
    decodeStage decode (
        .clk(clk),
        .rst(rst),
        .en(en),
        .redirect(redirect),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .retValid(retValid),
        .retRd(retRd),
        .retData(retData),
        .retWrites(retWrites),
        .decValid(decValid),
        .decPc(decPc),
        .decAluOp(decAluOp),
        .decBranchKind(decBranchKind),
        .decRd(decRd),
        .decRs1(decRs1),
        .decRs2(decRs2),
        .decOpA(decOpA),
        .decOpB(decOpB),
        .decImm(decImm),
        .decWrites(decWrites)
    );

    executeStage execute (
        .clk(clk),
        .rst(rst),
        .en(en),
        .decValid(decValid),
        .decPc(decPc),
        .decAluOp(decAluOp),
        .decBranchKind(decBranchKind),
        .decRd(decRd),
        .decRs1(decRs1),
        .decRs2(decRs2),
        .decOpA(decOpA),
        .decOpB(decOpB),
        .decImm(decImm),
        .decWrites(decWrites),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .retValid(retValid),
        .retPc(retPc),
        .retRd(retRd),
        .retData(retData),
        .retWrites(retWrites)
    );

endmodule

// File: tests/miniCoreTb.sv
`include "pipe_consts.svh"

module miniCoreTb;

    localparam int bodyWords = 240;
    localparam int retireTarget = 400;
    localparam int cycleLimit = 4000;

    logic clk;
    logic rst;
    logic en;
    logic [`XLEN-1:0] instrAddr;
    logic [`INSTR_W-1:0] instrData;
    logic retValid;
    logic [`XLEN-1:0] retPc;
    logic [`REG_ADDR_W-1:0] retRd;
    logic [`XLEN-1:0] retData;
    logic retWrites;

    logic [`INSTR_W-1:0] progMem [256];
    logic [`XLEN-1:0] modelRegs [32];
    logic [`XLEN-1:0] modelPc;
    logic [`XLEN-1:0] heldAddr;
    logic holdCheck;
    logic [`XLEN-1:0] expPc;
    logic [`REG_ADDR_W-1:0] expRd;
    logic [`XLEN-1:0] expData;
    logic expWr;
    int errorCount;
    int retireCount;
    int cycles;
    int lowLeft;

    miniCore dut (
        .clk(clk),
        .rst(rst),
        .en(en),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .retValid(retValid),
        .retPc(retPc),
        .retRd(retRd),
        .retData(retData),
        .retWrites(retWrites)
    );

    always #50 clk = ~clk;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = $urandom_range(0, 7);
        return r[4:0];
    endfunction

    function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [12:0] off);
        encodeBranch = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encodeJal(input logic [4:0] rd, input logic [20:0] off);
        encodeJal = {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    // x1..x7 get known values first, then a random body, then jal-to-self padding
    task automatic buildProgram();
        int i;
        int kind;
        logic [31:0] word;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        for (i = 0; i < 256; i++)
            progMem[i] = encodeJal(5'd0, 21'd0);
        for (i = 1; i < 8; i++) begin
            word = $urandom;
            rd = 5'(i);
            progMem[i - 1] = {word[11:0], 5'd0, `F3_ADD, rd, `OPC_OPIMM};
        end
        for (i = 7; i < bodyWords; i++) begin
            kind = $urandom_range(0, 99);
            rd = pickReg();
            rs1 = pickReg();
            rs2 = pickReg();
            word = $urandom;
            f3 = word[14:12];
            // alt funct7 only for sub and sra/srai
            f7 = ((f3 == `F3_ADD || f3 == `F3_SR) && word[30]) ? `F7_ALT : `F7_BASE;
            if (kind < 35) begin
                progMem[i] = {f7, rs2, rs1, f3, rd, `OPC_OP};
            end else if (kind < 65) begin
                if (f3 == `F3_SLL || f3 == `F3_SR)
                    word[31:25] = f7;
                progMem[i] = {word[31:20], rs1, f3, rd, `OPC_OPIMM};
            end else if (kind < 75) begin
                progMem[i] = {word[31:12], rd, `OPC_LUI};
            end else if (kind < 93) begin
                if (word[0])
                    rs2 = rs1;
                word = $urandom_range(2, 6) * 4;
                f3 = (kind < 85) ? `F3_BEQ : `F3_BNE;
                progMem[i] = encodeBranch(f3, rs1, rs2, word[12:0]);
            end else begin
                word = $urandom_range(2, 6) * 4;
                progMem[i] = encodeJal(rd, word[20:0]);
            end
        end
    endtask

    function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `F3_ADD: aluResult = alt ? a - b : a + b;
            `F3_SLL: aluResult = a << b[4:0];
            `F3_SLT: aluResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU: aluResult = (a < b) ? 32'd1 : 32'd0;
            `F3_XOR: aluResult = a ^ b;
            `F3_SR: begin
                if (alt)
                    aluResult = $signed(a) >>> b[4:0];
                else
                    aluResult = a >> b[4:0];
            end
            `F3_OR: aluResult = a | b;
            default: aluResult = a & b;
        endcase
    endfunction

    // executes one instruction of the architectural model
    function automatic void stepModel(output logic [31:0] pc, output logic [4:0] rd,
                                      output logic [31:0] data, output logic wr);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nextPc;
        logic [2:0] f3;
        ins = progMem[modelPc[9:2]];
        f3 = ins[14:12];
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        pc = modelPc;
        rd = 5'd0;
        data = 32'd0;
        wr = 1'b0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            `OPC_OP: begin
                wr = 1'b1;
                rd = ins[11:7];
                data = aluResult(f3, ins[30], a, b);
            end
            `OPC_OPIMM: begin
                wr = 1'b1;
                rd = ins[11:7];
                data = aluResult(f3, f3 == `F3_SR && ins[30],
                                 a, {{20{ins[31]}}, ins[31:20]});
            end
            `OPC_LUI: begin
                wr = 1'b1;
                rd = ins[11:7];
                data = {ins[31:12], 12'd0};
            end
            `OPC_BRANCH: begin
                if ((f3 == `F3_BEQ) ? (a == b) : (a != b))
                    nextPc = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
            end
            default: begin
                wr = 1'b1;
                rd = ins[11:7];
                data = modelPc + 32'd4;
                nextPc = modelPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
            end
        endcase
        if (wr && rd != 5'd0)
            modelRegs[rd] = data;
        modelPc = nextPc;
    endfunction

    // memory answers the address shown in the current cycle
    initial begin
        instrData = '0;
        forever begin
            @(negedge clk);
            instrData = progMem[instrAddr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // pc must not have moved across the previous held edge
            if (holdCheck)
                compareValue("instrAddr", heldAddr, instrAddr);
            holdCheck = !en;
            if (!en)
                compareValue("retValid", 32'd0, 32'(retValid));
            if (retValid) begin
                stepModel(expPc, expRd, expData, expWr);
                compareValue("retPc", expPc, retPc);
                compareValue("retRd", 32'(expRd), 32'(retRd));
                compareValue("retWrites", 32'(expWr), 32'(retWrites));
                if (expWr)
                    compareValue("retData", expData, retData);
                retireCount++;
            end
        end
    end

    initial begin
        void'($urandom(32'hc3acb622));
        clk = 1'b0;
        rst = 1'b1;
        en = 1'b1;
        errorCount = 0;
        retireCount = 0;
        lowLeft = 0;
        heldAddr = `RESET_PC;
        holdCheck = 1'b0;
        modelPc = `RESET_PC;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        buildProgram();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compareValue("retValid", 32'd0, 32'(retValid));
        compareValue("instrAddr", `RESET_PC, instrAddr);
        cycles = 0;
        while (retireCount < retireTarget && cycles < cycleLimit) begin
            @(negedge clk);
            // short hold windows of 1 to 4 cycles
            if (lowLeft != 0) begin
                lowLeft--;
                en = 1'b0;
            end else if (en && $urandom_range(0, 19) == 0) begin
                lowLeft = $urandom_range(0, 3);
                heldAddr = instrAddr;
                en = 1'b0;
            end else begin
                en = 1'b1;
            end
            cycles++;
        end
        if (retireCount < retireTarget) begin
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retireCount, retireTarget, cycleLimit);
            errorCount++;
        end
        $display("errors=%0d retired=%0d cycles=%0d", errorCount, retireCount, cycles);
        if (errorCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: miniCore.f
+incdir+rtl
rtl/pipePkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/miniCore.sv
tests/miniCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= miniCoreTb
FILELIST ?= miniCore.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
